/* cpuControl.f */
+incdir+include
hdl/cpuControlPkg.sv
hdl/phaseSequencer.sv
hdl/branchConditionUnit.sv
hdl/instructionDecoder.sv
hdl/cpuControl.sv
dv/cpuControlTb.sv

/* run.sh */
#!/bin/sh
# Build and run the cpuControl testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f cpuControl.f \
    --top-module cpuControlTb \
    -o cpuControlSim

./obj_dir/cpuControlSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB PASSED" sim.log; then
    exit 0
fi
exit 1

/* dv/cpuControlTb.sv */
`timescale 1ns/1ps

`include "cpuControl_defs.svh"

module cpuControlTb;

    import cpuControlPkg::*;

    localparam int NumInstructions = 400;
    localparam int CycleLimit = 2000;  // 400 x 4 cycles plus margin

    typedef enum int {
        kindRegAlu, kindCompare, kindLogicImm, kindArithImm, kindLui, kindShift,
        kindLoad, kindStore, kindJcond, kindJal, kindBcond, kindUnsupported
    } kind_e;

    logic         clock;
    logic         reset;
    instruction_t instruction;
    psrFlags_t    flags;
    controlBus_t  control;

    integer seed;
    int     cycleCount = 0;
    int     doneCount;
    phase_e modelPhase;
    logic   midRunResetDone;

    cpuControl cpuControl_i (
        .clock       (clock),
        .reset       (reset),
        .instruction (instruction),
        .flags       (flags),
        .control     (control)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", CycleLimit);
            $display("TB FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    function automatic kind_e kindOf(input instruction_t ins);
        kind_e k;
        k = kindUnsupported;
        case (ins.major)
            opRType: k = (ins.ext == `CPU_EXT_CMP) ? kindCompare : kindRegAlu;
            opCmpi: k = kindCompare;
            opAndi, opOri, opXori, opMovi: k = kindLogicImm;
            opAddi, opSubi: k = kindArithImm;
            opLui: k = kindLui;
            opShift: k = kindShift;
            opBcond: k = kindBcond;
            opMem: begin
                if (ins.ext == `CPU_EXT_LOAD) k = kindLoad;
                else if (ins.ext == `CPU_EXT_STORE) k = kindStore;
                else if (ins.ext == `CPU_EXT_JAL) k = kindJal;
                else if (ins.ext == `CPU_EXT_JCOND) k = kindJcond;
            end
            default: k = kindUnsupported;  // ADDUI, ADDCI, SUBCI, MULI
        endcase
        return k;
    endfunction

    function automatic logic conditionHolds(input logic [3:0] code, input psrFlags_t f);
        logic taken;
        taken = 1'b0;
        case (condCode_e'(code))
            condEq: taken = f.zero;
            condNe: taken = ~f.zero;
            condCs: taken = f.carry;
            condCc: taken = ~f.carry;
            condHi: taken = f.low;
            condLs: taken = ~f.low;
            condGt: taken = f.negative;
            condLe: taken = ~f.negative;
            condFs: taken = f.flag;
            condFc: taken = ~f.flag;
            condLo: taken = ~(f.low | f.zero);
            condHs: taken = f.low | f.zero;
            condLt: taken = ~(f.negative | f.zero);
            condGe: taken = f.negative | f.zero;
            condUc: taken = 1'b1;
            default: taken = 1'b0;  // NJ
        endcase
        return taken;
    endfunction

    function automatic controlBus_t expectControl(input phase_e ph, input instruction_t ins,
                                                  input psrFlags_t fl);
        controlBus_t c;
        kind_e       k;
        logic        writesReg;
        logic        regShift;
        c = '0;
        c.useRegisterA = 1'b1;
        k = kindOf(ins);
        writesReg = k inside {kindRegAlu, kindLogicImm, kindArithImm, kindLui, kindShift, kindLoad};
        regShift = (ins.ext == `CPU_EXT_LSH) || (ins.ext == `CPU_EXT_ASH);
        if (ph == phaseFetch) begin
            c.ramReadEnable = 1'b1;
            c.irLoad = 1'b1;
        end else if (ph == phaseExecute) begin
            c.aluEnable = 1'b1;
            case (k)
                kindCompare: begin
                    c.useImmediate = (ins.major == opCmpi);
                    c.immKind = immSigned;
                    c.pcEnable = 1'b1;
                end
                kindLogicImm: begin
                    c.useImmediate = 1'b1;
                    c.immKind = immZero;
                end
                kindArithImm: begin
                    c.useImmediate = 1'b1;
                    c.immKind = immSigned;
                end
                kindLui: c.useImmediate = 1'b1;  // immUpper is zero
                kindShift: c.useImmediate = !regShift;
                kindLoad: begin
                    c.ramAddressFromAlu = 1'b1;
                    c.ramReadEnable = 1'b1;
                end
                kindStore, kindJcond, kindJal: begin
                    c.useImmediate = 1'b1;
                    c.immKind = immNone;
                end
                kindBcond: begin
                    c.useImmediate = 1'b1;
                    c.useRegisterA = 1'b0;
                end
                kindUnsupported: c.pcEnable = 1'b1;
                default: ;
            endcase
        end else if (ph == phaseWriteBack) begin
            c.pcEnable = 1'b1;
            if (writesReg) begin
                c.regWriteEnable = 1'b1;
                c.regWriteAddress = ins.rDest;
            end
            if (k == kindLoad) begin
                c.ramAddressFromAlu = 1'b1;
                c.writeBackFromRam = 1'b1;
                c.ramReadEnable = 1'b1;
            end
            if (k == kindStore) c.ramWriteEnable = 1'b1;
            if (k == kindBcond || k == kindJcond) c.pcLoad = conditionHolds(ins.rDest, fl);
            if (k == kindJal) c.pcLoad = 1'b1;
        end
        return c;
    endfunction

    function automatic phase_e nextModelPhase(input phase_e ph, input instruction_t ins);
        kind_e  k;
        phase_e nxt;
        k = kindOf(ins);
        case (ph)
            phaseFetch: nxt = phaseDecode;
            phaseDecode: nxt = phaseExecute;
            phaseExecute: begin
                nxt = (k == kindCompare || k == kindUnsupported) ? phaseFetch : phaseWriteBack;
            end
            default: nxt = phaseFetch;
        endcase
        return nxt;
    endfunction

    // New word and flags, biased toward memory, jump and compare encodings
    task automatic drawStimulus();
        int           pick;
        instruction_t ins;
        pick = $unsigned($random(seed)) % 9;
        ins = instruction_t'(16'($random(seed)));
        case (pick)
            3: begin
                ins.major = opMem;
                ins.ext = `CPU_EXT_LOAD;
            end
            4: begin
                ins.major = opMem;
                ins.ext = `CPU_EXT_STORE;
            end
            5: begin
                ins.major = opMem;
                ins.ext = `CPU_EXT_JAL;
            end
            6: begin
                ins.major = opMem;
                ins.ext = `CPU_EXT_JCOND;
            end
            7: begin
                if ($random(seed) & 1) begin
                    ins.major = opRType;
                    ins.ext = `CPU_EXT_CMP;
                end else begin
                    ins.major = opCmpi;
                end
            end
            8: ins.major = opBcond;
            default: ;  // Fully random word
        endcase
        instruction = ins;
        flags = psrFlags_t'(5'($random(seed)));
    endtask

    task automatic checkControl(input controlBus_t expected);
        assert (control === expected) else begin
            $display("MISMATCH time=%0t signal=control expected=%h actual=%h",
                     $time, expected, control);
            $display("TB FAILED");
            $fatal(1, "control bus check failed");
        end
    endtask

    // Reset during decode must force fetch instead of execute
    task automatic resetMidInstruction();
        reset = 1'b0;
        @(negedge clock);
        checkControl(expectControl(modelPhase, instruction, flags));  // Not yet sampled
        repeat (2) begin
            @(negedge clock);
            checkControl(expectControl(phaseFetch, instruction, flags));
        end
        @(posedge clock);  // Third reset edge
        #1;
        reset = 1'b1;
        modelPhase = phaseFetch;
    endtask

    initial begin
        seed = 32'ha9b5;
        reset = 1'b0;
        instruction = '0;
        flags = '0;
        modelPhase = phaseFetch;
        doneCount = 0;
        midRunResetDone = 1'b0;
        repeat (2) begin
            @(negedge clock);
            checkControl(expectControl(phaseFetch, instruction, flags));
        end
        @(posedge clock);  // Third reset edge
        #1;
        reset = 1'b1;
        while (doneCount < NumInstructions) begin
            if (modelPhase == phaseFetch) begin
                drawStimulus();
            end
            @(negedge clock);  // Outputs settled mid cycle
            checkControl(expectControl(modelPhase, instruction, flags));
            modelPhase = nextModelPhase(modelPhase, instruction);
            if (modelPhase == phaseFetch) begin
                doneCount++;
            end
            @(posedge clock);
            #1;
            if (!midRunResetDone && doneCount == NumInstructions / 2
                    && modelPhase == phaseDecode) begin
                midRunResetDone = 1'b1;
                resetMidInstruction();
            end
        end
        @(negedge clock);
        checkControl(expectControl(modelPhase, instruction, flags));
        $display("TB PASSED");
        $finish;
    end

endmodule

/* hdl/cpuControl.sv */
`timescale 1ns/1ps

module cpuControl (
    input  logic                         clock,
    input  logic                         reset,
    input  cpuControlPkg::instruction_t  instruction,
    input  cpuControlPkg::psrFlags_t     flags,
    output cpuControlPkg::controlBus_t   control
);

    import cpuControlPkg::*;

    phase_e phase;
    logic   skipWriteBack;
    logic   conditionTrue;

    phaseSequencer phaseSequencer_i (
        .clock         (clock),
        .reset         (reset),
        .skipWriteBack (skipWriteBack),
        .phase         (phase)
    );

    instructionDecoder instructionDecoder_i (
        .phase         (phase),
        .instruction   (instruction),
        .conditionTrue (conditionTrue),
        .skipWriteBack (skipWriteBack),
        .control       (control)
    );

    // rDest carries the condition code for Bcond and Jcond
    branchConditionUnit branchConditionUnit_i (
        .condition     (condCode_e'(instruction.rDest)),
        .flags         (flags),
        .conditionTrue (conditionTrue)
    );

endmodule

/* hdl/instructionDecoder.sv */
`timescale 1ns/1ps

`include "cpuControl_defs.svh"

module instructionDecoder (
    input  cpuControlPkg::phase_e        phase,
    input  cpuControlPkg::instruction_t  instruction,
    input  logic                         conditionTrue,
    output logic                         skipWriteBack,
    output cpuControlPkg::controlBus_t   control
);

    import cpuControlPkg::*;

    typedef enum logic [3:0] {
        classRegAlu,
        classCompare,
        classLogicImm,
        classArithImm,
        classLui,
        classShiftReg,
        classShiftImm,
        classLoad,
        classStore,
        classJcond,
        classJal,
        classBcond,
        classUnsupported
    } instrClass_e;

    instrClass_e instrClass;

    always_comb begin
        instrClass = classUnsupported;  // ADDUI, ADDCI, SUBCI, MULI land here
        case (instruction.major)
            opRType: begin
                if (instruction.ext == `CPU_EXT_CMP) begin
                    instrClass = classCompare;
                end else begin
                    instrClass = classRegAlu;
                end
            end
            opAndi, opOri, opXori, opMovi: instrClass = classLogicImm;
            opAddi, opSubi: instrClass = classArithImm;
            opCmpi: instrClass = classCompare;
            opLui: instrClass = classLui;
            opBcond: instrClass = classBcond;
            opShift: begin
                if (instruction.ext == `CPU_EXT_LSH || instruction.ext == `CPU_EXT_ASH) begin
                    instrClass = classShiftReg;
                end else begin
                    instrClass = classShiftImm;
                end
            end
            opMem: begin
                case (instruction.ext)
                    `CPU_EXT_LOAD: instrClass = classLoad;
                    `CPU_EXT_STORE: instrClass = classStore;
                    `CPU_EXT_JAL: instrClass = classJal;
                    `CPU_EXT_JCOND: instrClass = classJcond;
                    default: instrClass = classUnsupported;
                endcase
            end
            default: instrClass = classUnsupported;
        endcase
    end

    assign skipWriteBack = (instrClass == classCompare) || (instrClass == classUnsupported);

    always_comb begin
        control = '0;
        control.useRegisterA = 1'b1;
        case (phase)
            phaseFetch: begin
                control.ramReadEnable = 1'b1;
                control.irLoad = 1'b1;
            end
            phaseExecute: begin
                control.aluEnable = 1'b1;
                case (instrClass)
                    classCompare: begin
                        control.useImmediate = (instruction.major == opCmpi);
                        control.immKind = immSigned;
                        control.pcEnable = 1'b1;  // No write back follows
                    end
                    classLogicImm: begin
                        control.useImmediate = 1'b1;
                        control.immKind = immZero;
                    end
                    classArithImm: begin
                        control.useImmediate = 1'b1;
                        control.immKind = immSigned;
                    end
                    classLui, classShiftImm: begin
                        control.useImmediate = 1'b1;
                        control.immKind = immUpper;
                    end
                    classLoad: begin
                        control.ramAddressFromAlu = 1'b1;
                        control.ramReadEnable = 1'b1;
                    end
                    classStore, classJcond, classJal: begin
                        control.useImmediate = 1'b1;
                        control.immKind = immNone;  // Address straight from rSrc
                    end
                    classBcond: begin
                        control.useImmediate = 1'b1;
                        control.immKind = immUpper;
                        control.useRegisterA = 1'b0;  // PC plus offset
                    end
                    classUnsupported: begin
                        control.pcEnable = 1'b1;
                    end
                    default: ;
                endcase
            end
            phaseWriteBack: begin
                control.pcEnable = 1'b1;
                case (instrClass)
                    classLoad: begin
                        control.regWriteEnable = 1'b1;
                        control.regWriteAddress = instruction.rDest;
                        control.ramAddressFromAlu = 1'b1;
                        control.writeBackFromRam = 1'b1;
                        control.ramReadEnable = 1'b1;
                    end
                    classStore: begin
                        control.ramWriteEnable = 1'b1;
                    end
                    classBcond, classJcond: begin
                        control.pcLoad = conditionTrue;
                    end
                    classJal: begin
                        control.pcLoad = 1'b1;
                    end
                    classRegAlu, classLogicImm, classArithImm, classLui,
                    classShiftReg, classShiftImm: begin
                        control.regWriteEnable = 1'b1;
                        control.regWriteAddress = instruction.rDest;
                    end
                    default: ;
                endcase
            end
            default: ;  // Decode drives nothing
        endcase
    end

endmodule

/* hdl/branchConditionUnit.sv */
`timescale 1ns/1ps

module branchConditionUnit (
    input  cpuControlPkg::condCode_e  condition,
    input  cpuControlPkg::psrFlags_t  flags,
    output logic                      conditionTrue
);

    import cpuControlPkg::*;

    always_comb begin
        conditionTrue = 1'b0;
        case (condition)
            condEq: conditionTrue = flags.zero;
            condNe: conditionTrue = !flags.zero;
            condCs: conditionTrue = flags.carry;
            condCc: conditionTrue = !flags.carry;
            condHi: conditionTrue = flags.low;
            condLs: conditionTrue = !flags.low;
            condGt: conditionTrue = flags.negative;
            condLe: conditionTrue = !flags.negative;
            condFs: conditionTrue = flags.flag;
            condFc: conditionTrue = !flags.flag;
            condLo: begin
                conditionTrue = !flags.low && !flags.zero;
            end
            condHs: begin
                conditionTrue = flags.low || flags.zero;
            end
            condLt: begin
                conditionTrue = !flags.negative && !flags.zero;
            end
            condGe: begin
                conditionTrue = flags.negative || flags.zero;
            end
            condUc: conditionTrue = 1'b1;
            condNj: conditionTrue = 1'b0;  // Never taken
            default: conditionTrue = 1'b0;
        endcase
    end

endmodule

/* hdl/phaseSequencer.sv */
`timescale 1ns/1ps

module phaseSequencer (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   skipWriteBack,
    output cpuControlPkg::phase_e  phase
);

    import cpuControlPkg::*;

    phase_e nextPhase;

    always_comb begin
        nextPhase = phaseFetch;
        case (phase)
            phaseFetch: begin
                nextPhase = phaseDecode;
            end
            phaseDecode: begin
                nextPhase = phaseExecute;
            end
            phaseExecute: begin
                // Compares and unsupported codes have nothing to write
                if (skipWriteBack) begin
                    nextPhase = phaseFetch;
                end else begin
                    nextPhase = phaseWriteBack;
                end
            end
            phaseWriteBack: begin
                nextPhase = phaseFetch;
            end
            default: begin
                nextPhase = phaseFetch;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            phase <= phaseFetch;
        end else begin
            phase <= nextPhase;
        end
    end

endmodule

/* hdl/cpuControlPkg.sv */
package cpuControlPkg;

`include "cpuControl_defs.svh"

    localparam int MajorWidth = `CPU_INSTR_WIDTH - 2 * `CPU_REG_ADDR_WIDTH - `CPU_EXT_WIDTH;

    typedef enum logic [1:0] {
        phaseFetch,
        phaseDecode,
        phaseExecute,
        phaseWriteBack
    } phase_e;

    typedef enum logic [MajorWidth-1:0] {
        opRType,
        opAndi,
        opOri,
        opXori,
        opMem,  // Load, store, Jcond, JAL
        opAddi,
        opAddui,
        opAddci,
        opShift,
        opSubi,
        opSubci,
        opCmpi,
        opBcond,
        opMovi,
        opMuli,
        opLui
    } majorOp_e;

    typedef enum logic [1:0] {
        immUpper  = 2'd0,  // Raw low byte
        immSigned = 2'd1,
        immZero   = 2'd2,
        immNone   = 2'd3   // Forced zero
    } immKind_e;

    typedef enum logic [`CPU_REG_ADDR_WIDTH-1:0] {
        condEq, condNe, condCs, condCc,
        condHi, condLs, condGt, condLe,
        condFs, condFc, condLo, condHs,
        condLt, condGe, condUc, condNj
    } condCode_e;

    typedef struct packed {
        majorOp_e                       major;
        logic [`CPU_REG_ADDR_WIDTH-1:0] rDest;  // Also the condition code
        logic [`CPU_EXT_WIDTH-1:0]      ext;
        logic [`CPU_REG_ADDR_WIDTH-1:0] rSrc;
    } instruction_t;

    typedef struct packed {
        logic negative;
        logic zero;
        logic flag;
        logic low;
        logic carry;
    } psrFlags_t;

    typedef struct packed {
        logic                           pcEnable;
        logic                           pcLoad;
        logic                           irLoad;
        logic                           ramReadEnable;
        logic                           ramWriteEnable;
        logic                           aluEnable;
        logic                           regWriteEnable;
        logic                           useImmediate;
        logic                           useRegisterA;     // Low selects the PC
        logic                           ramAddressFromAlu;
        logic                           writeBackFromRam;
        immKind_e                       immKind;
        logic [`CPU_REG_ADDR_WIDTH-1:0] regWriteAddress;
    } controlBus_t;

endpackage

/* include/cpuControl_defs.svh */
`ifndef CPU_CONTROL_DEFS_SVH
`define CPU_CONTROL_DEFS_SVH

// Instruction word layout: major | rDest | ext | rSrc
`define CPU_INSTR_WIDTH 16
`define CPU_REG_ADDR_WIDTH 4
`define CPU_EXT_WIDTH 4

// Extension codes under opRType
`define CPU_EXT_CMP 4'b1011

// Extension codes under opMem
`define CPU_EXT_LOAD 4'b0000
`define CPU_EXT_STORE 4'b0100
`define CPU_EXT_JAL 4'b1000
`define CPU_EXT_JCOND 4'b1100

// Extension codes under opShift that take the shift count from a register
`define CPU_EXT_LSH 4'b0100
`define CPU_EXT_ASH 4'b0110

`endif
